//--- common/fft_pkg.sv
package fft_pkg;

  // default sample width and fixed-point position
  localparam int DATA_W = 32;
  localparam int FRAC_W = 16; // fraction bits dropped after each product

  // twiddle table for a 32-point FFT holds the first half circle
  localparam int TW_DEPTH = 16;
  localparam int TW_ADDR_W = 4;

  // complex multiplier builds
  localparam int MULTS_SERIAL = 1;   // one multiplier reused over three cycles
  localparam int MULTS_PARALLEL = 3; // three multipliers, combinational

  // each line of twiddle.mem is one ROM word of 2*n bits
  // with the real part in the upper half and the imaginary part in the lower half

endpackage

//--- common/cplx_if.sv
`timescale 1ns/1ps

// one complex value with a valid/ready handshake
interface cplx_if import fft_pkg::*; #(
  parameter int n = DATA_W
) ();

  logic val;
  logic rdy;
  logic [n-1:0] re;
  logic [n-1:0] im;

  // the source holds re and im steady from val until the transfer
  modport source (
    output val,
    output re,
    output im,
    input  rdy
  );

  modport sink (
    input  val,
    input  re,
    input  im,
    output rdy
  );

endinterface

//--- source/fp_mult.sv
`timescale 1ns/1ps

// signed fixed-point multiply, c = (a * b) >> d with wrap to n bits
module fp_mult import fft_pkg::*; #(
  parameter int n = DATA_W,
  parameter int d = FRAC_W
) (
  input  logic [n-1:0] a,
  input  logic [n-1:0] b,
  output logic [n-1:0] c
);

  logic signed [2*n-1:0] a_ext;
  logic signed [2*n-1:0] b_ext;
  logic signed [2*n-1:0] prod;
  logic signed [2*n-1:0] shifted;

  assign a_ext = {{n{a[n-1]}}, a};
  assign b_ext = {{n{b[n-1]}}, b};

  // the full signed product always fits in 2n bits
  assign prod = a_ext * b_ext;

  // truncation toward minus infinity, then wrap by keeping the low word
  assign shifted = prod >>> d;
  assign c = shifted[n-1:0];

endmodule

//--- cmult/cmult.sv
`timescale 1ns/1ps

// complex multiply p = w * b
//   p_re = w_re*b_re - w_im*b_im
//   p_im = (w_re + w_im)(b_re + b_im) - w_re*b_re - w_im*b_im
// the operand sums wrap to n bits before they are multiplied
module cmult import fft_pkg::*; #(
  parameter int n = DATA_W,
  parameter int d = FRAC_W,
  parameter int num_mults = MULTS_SERIAL
) (
  input  logic clk,
  input  logic reset,
  cplx_if.sink opnd,
  input  logic [n-1:0] w_re,
  input  logic [n-1:0] w_im,
  cplx_if.source prod
);

  logic [n-1:0] re_x_re;   // w_re * b_re
  logic [n-1:0] im_x_im;   // w_im * b_im
  logic [n-1:0] sum_x_sum; // (w_re + w_im) * (b_re + b_im)
  logic recv_rdy;
  logic send_val;

  generate
    if (num_mults == MULTS_PARALLEL) begin : g_parallel
      logic [n-1:0] w_sum;
      logic [n-1:0] b_sum;

      assign w_sum = w_re + w_im;
      assign b_sum = opnd.re + opnd.im;

      fp_mult #(.n(n), .d(d)) u_mult_re (
        .a(w_re),
        .b(opnd.re),
        .c(re_x_re)
      );

      fp_mult #(.n(n), .d(d)) u_mult_im (
        .a(w_im),
        .b(opnd.im),
        .c(im_x_im)
      );

      fp_mult #(.n(n), .d(d)) u_mult_sum (
        .a(w_sum),
        .b(b_sum),
        .c(sum_x_sum)
      );

      // no storage here, the handshake passes straight through
      assign recv_rdy = prod.rdy;
      assign send_val = opnd.val;
    end else begin : g_serial
      localparam logic [2:0] IDLE = 3'd0;
      localparam logic [2:0] MUL1 = 3'd1;
      localparam logic [2:0] MUL2 = 3'd2;
      localparam logic [2:0] MUL3 = 3'd3;
      localparam logic [2:0] DONE = 3'd4;

      logic [2:0] state;
      logic [2:0] next_state;
      logic [n-1:0] w_re_q;
      logic [n-1:0] w_im_q;
      logic [n-1:0] b_re_q;
      logic [n-1:0] b_im_q;
      logic [n-1:0] mul_a;
      logic [n-1:0] mul_b;
      logic [n-1:0] mul_c;

      always_ff @(posedge clk) begin
        if (reset) begin
          state <= IDLE;
        end else begin
          state <= next_state;
        end
      end

      // operands are captured once, partial products land one per cycle
      always_ff @(posedge clk) begin
        case (state)
          IDLE: begin
            if (opnd.val) begin
              w_re_q <= w_re;
              w_im_q <= w_im;
              b_re_q <= opnd.re;
              b_im_q <= opnd.im;
            end
          end
          MUL1: re_x_re <= mul_c;
          MUL2: im_x_im <= mul_c;
          MUL3: sum_x_sum <= mul_c;
          default: ;
        endcase
      end

      always_comb begin
        next_state = state;
        recv_rdy = 1'b0;
        send_val = 1'b0;
        mul_a = '0;
        mul_b = '0;
        case (state)
          IDLE: begin
            recv_rdy = 1'b1;
            if (opnd.val) next_state = MUL1;
          end
          MUL1: begin
            mul_a = w_re_q;
            mul_b = b_re_q;
            next_state = MUL2;
          end
          MUL2: begin
            mul_a = w_im_q;
            mul_b = b_im_q;
            next_state = MUL3;
          end
          MUL3: begin
            mul_a = w_re_q + w_im_q; // sums wrap to n bits
            mul_b = b_re_q + b_im_q;
            next_state = DONE;
          end
          DONE: begin
            send_val = 1'b1;
            if (prod.rdy) next_state = IDLE; // result stays put until taken
          end
          default: next_state = IDLE;
        endcase
      end

      fp_mult #(.n(n), .d(d)) u_mult (
        .a(mul_a),
        .b(mul_b),
        .c(mul_c)
      );
    end
  endgenerate

  assign opnd.rdy = recv_rdy;
  assign prod.val = send_val;
  assign prod.re = re_x_re - im_x_im;
  assign prod.im = sum_x_sum - re_x_re - im_x_im;

endmodule

//--- source/twiddle_rom.sv
`timescale 1ns/1ps

// twiddle table with a registered read, w is valid the cycle after addr
module twiddle_rom import fft_pkg::*; #(
  parameter int n = DATA_W,
  parameter int depth = TW_DEPTH
) (
  input  logic clk,
  input  logic [TW_ADDR_W-1:0] addr,
  output logic [n-1:0] w_re,
  output logic [n-1:0] w_im
);

  logic [2*n-1:0] mem [depth];
  logic [2*n-1:0] word;

  initial begin
    $readmemh("twiddle.mem", mem);
  end

  always_ff @(posedge clk) begin
    word <= mem[addr];
  end

  assign w_re = word[2*n-1:n]; // real half sits in the upper bits
  assign w_im = word[n-1:0];

endmodule

//--- source/bfly_issue.sv
`timescale 1ns/1ps

// input stage: holds one butterfly request, waits a cycle for the twiddle,
// then hands b to the multiplier and a to the combine stage together
module bfly_issue import fft_pkg::*; #(
  parameter int n = DATA_W
) (
  input  logic clk,
  input  logic reset,
  input  logic in_val,
  output logic in_rdy,
  input  logic [n-1:0] a_re,
  input  logic [n-1:0] a_im,
  input  logic [n-1:0] b_re,
  input  logic [n-1:0] b_im,
  input  logic [TW_ADDR_W-1:0] k,
  cplx_if.source opnd,
  cplx_if.source a_out,
  output logic [n-1:0] w_re,
  output logic [n-1:0] w_im
);

  logic full;  // a request is held
  logic phase; // the ROM word for the held request is ready
  logic take;
  logic issue;
  logic [n-1:0] a_re_q;
  logic [n-1:0] a_im_q;
  logic [n-1:0] b_re_q;
  logic [n-1:0] b_im_q;
  logic [TW_ADDR_W-1:0] k_q;

  assign in_rdy = !full;
  assign take = in_val && !full;

  // both sinks must take the request in the same cycle
  assign issue = full && phase && opnd.rdy && a_out.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
      phase <= 1'b0;
    end else if (take) begin
      full <= 1'b1;
      phase <= 1'b0;
    end else if (issue) begin
      full <= 1'b0;
    end else if (full) begin
      phase <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      a_re_q <= a_re;
      a_im_q <= a_im;
      b_re_q <= b_re;
      b_im_q <= b_im;
      k_q <= k;
    end
  end

  twiddle_rom #(.n(n), .depth(TW_DEPTH)) u_twiddle_rom (
    .clk(clk),
    .addr(k_q), // keeps reading the held index, so w stays valid while stalled
    .w_re(w_re),
    .w_im(w_im)
  );

  assign opnd.val = issue;
  assign opnd.re = b_re_q;
  assign opnd.im = b_im_q;
  assign a_out.val = issue;
  assign a_out.re = a_re_q;
  assign a_out.im = a_im_q;

endmodule

//--- source/bfly_combine.sv
`timescale 1ns/1ps

// output stage: pairs a with the product and registers x = a + p, y = a - p
module bfly_combine import fft_pkg::*; #(
  parameter int n = DATA_W
) (
  input  logic clk,
  input  logic reset,
  cplx_if.sink a_in,
  cplx_if.sink prod,
  output logic out_val,
  input  logic out_rdy,
  output logic [n-1:0] x_re,
  output logic [n-1:0] x_im,
  output logic [n-1:0] y_re,
  output logic [n-1:0] y_im
);

  logic a_full;
  logic p_full;
  logic out_full;
  logic a_take;
  logic p_take;
  logic a_here;
  logic p_here;
  logic out_free;
  logic fire;
  logic [n-1:0] a_re_q;
  logic [n-1:0] a_im_q;
  logic [n-1:0] p_re_q;
  logic [n-1:0] p_im_q;
  logic [n-1:0] a_re_s;
  logic [n-1:0] a_im_s;
  logic [n-1:0] p_re_s;
  logic [n-1:0] p_im_s;

  assign a_in.rdy = !a_full;
  assign prod.rdy = !p_full;
  assign a_take = a_in.val && !a_full;
  assign p_take = prod.val && !p_full;

  // a value counts as present when it sits in its slot or arrives now
  assign a_here = a_full || a_in.val;
  assign p_here = p_full || prod.val;
  assign out_free = !out_full || out_rdy;
  assign fire = a_here && p_here && out_free;

  assign a_re_s = a_full ? a_re_q : a_in.re;
  assign a_im_s = a_full ? a_im_q : a_in.im;
  assign p_re_s = p_full ? p_re_q : prod.re;
  assign p_im_s = p_full ? p_im_q : prod.im;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_full <= 1'b0;
      p_full <= 1'b0;
      out_full <= 1'b0;
    end else begin
      if (fire) a_full <= 1'b0;
      else if (a_take) a_full <= 1'b1;
      if (fire) p_full <= 1'b0;
      else if (p_take) p_full <= 1'b1;
      if (fire) out_full <= 1'b1;
      else if (out_rdy) out_full <= 1'b0; // drained
    end
  end

  always_ff @(posedge clk) begin
    if (a_take) begin
      a_re_q <= a_in.re;
      a_im_q <= a_in.im;
    end
    if (p_take) begin
      p_re_q <= prod.re;
      p_im_q <= prod.im;
    end
    if (fire) begin
      x_re <= a_re_s + p_re_s; // sums and differences wrap mod 2^n
      x_im <= a_im_s + p_im_s;
      y_re <= a_re_s - p_re_s;
      y_im <= a_im_s - p_im_s;
    end
  end

  assign out_val = out_full;

endmodule

//--- source/fft_butterfly.sv
`timescale 1ns/1ps

// radix-2 DIT butterfly: x = a + w*b, y = a - w*b with w from the twiddle ROM
module fft_butterfly import fft_pkg::*; #(
  parameter int n = DATA_W,
  parameter int d = FRAC_W,
  parameter int num_mults = MULTS_SERIAL
) (
  input  logic clk,
  input  logic reset,
  input  logic in_val,
  output logic in_rdy,
  input  logic [n-1:0] a_re,
  input  logic [n-1:0] a_im,
  input  logic [n-1:0] b_re,
  input  logic [n-1:0] b_im,
  input  logic [TW_ADDR_W-1:0] k,
  output logic out_val,
  input  logic out_rdy,
  output logic [n-1:0] x_re,
  output logic [n-1:0] x_im,
  output logic [n-1:0] y_re,
  output logic [n-1:0] y_im
);

  logic [n-1:0] w_re; // valid while opnd_bus is valid
  logic [n-1:0] w_im;

  cplx_if #(.n(n)) opnd_bus ();
  cplx_if #(.n(n)) a_bus ();
  cplx_if #(.n(n)) prod_bus ();

  bfly_issue #(.n(n)) u_bfly_issue (
    .clk(clk),
    .reset(reset),
    .in_val(in_val),
    .in_rdy(in_rdy),
    .a_re(a_re),
    .a_im(a_im),
    .b_re(b_re),
    .b_im(b_im),
    .k(k),
    .opnd(opnd_bus),
    .a_out(a_bus),
    .w_re(w_re),
    .w_im(w_im)
  );

  cmult #(.n(n), .d(d), .num_mults(num_mults)) u_cmult (
    .clk(clk),
    .reset(reset),
    .opnd(opnd_bus),
    .w_re(w_re),
    .w_im(w_im),
    .prod(prod_bus)
  );

  bfly_combine #(.n(n)) u_bfly_combine (
    .clk(clk),
    .reset(reset),
    .a_in(a_bus),
    .prod(prod_bus),
    .out_val(out_val),
    .out_rdy(out_rdy),
    .x_re(x_re),
    .x_im(x_im),
    .y_re(y_re),
    .y_im(y_im)
  );

endmodule

//--- test/fft_butterfly_checker.sv
`timescale 1ns/1ps

// handshake rules on the output side of the butterfly
module fft_butterfly_checker import fft_pkg::*; #(
  parameter int n = DATA_W
) (
  input logic clk,
  input logic reset,
  input logic in_rdy,
  input logic out_val,
  input logic out_rdy,
  input logic [n-1:0] x_re,
  input logic [n-1:0] x_im,
  input logic [n-1:0] y_re,
  input logic [n-1:0] y_im
);

  // an offered result stays offered until it is taken
  hold_val: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val)
    else $error("out_val fell while out_rdy was low");

  hold_data: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> $stable({x_re, x_im, y_re, y_im}))
    else $error("outputs changed while a result was stalled");

  // the pipeline comes out of reset empty and ready
  reset_state: assert property (@(posedge clk) reset |=> in_rdy && !out_val)
    else $error("in_rdy or out_val wrong after reset");

endmodule

bind fft_butterfly fft_butterfly_checker #(.n(n)) u_fft_butterfly_checker (
  .clk(clk),
  .reset(reset),
  .in_rdy(in_rdy),
  .out_val(out_val),
  .out_rdy(out_rdy),
  .x_re(x_re),
  .x_im(x_im),
  .y_re(y_re),
  .y_im(y_im)
);

//--- test/fft_butterfly_tb.sv
`timescale 1ns/1ps

module fft_butterfly_tb import fft_pkg::*; #(
  parameter int num_mults = MULTS_SERIAL
) ();

  localparam int n = DATA_W;
  localparam int d = FRAC_W;
  localparam int num_reqs = 330;             // 6 + 200 + 16 + 100 + 8 requests
  localparam int max_cycles = 10 * num_reqs * 7;
  localparam int stall_min = 8;              // longer than any in_rdy gap without back-pressure

  logic clk = 1'b0;
  logic reset;
  logic in_val;
  logic in_rdy;
  logic [n-1:0] a_re;
  logic [n-1:0] a_im;
  logic [n-1:0] b_re;
  logic [n-1:0] b_im;
  logic [TW_ADDR_W-1:0] k;
  logic out_val;
  logic out_rdy;
  logic [n-1:0] x_re;
  logic [n-1:0] x_im;
  logic [n-1:0] y_re;
  logic [n-1:0] y_im;

  logic [2*n-1:0] tw_mem [TW_DEPTH];
  logic [4*n-1:0] exp_q [$];     // {x_re, x_im, y_re, y_im} in input order
  int seed = 25;
  int rdy_seed = 25 + 1;         // own stream so the ready pattern does not shift the data
  int rdy_mode = 0;              // 0 always ready, 1 random stalls, 2 hold until backed up
  int stall_cycles = 0;
  int cycles = 0;
  int n_out = 0;
  bit main_done = 1'b0;
  bit cmp_done = 1'b0;
  bit tmo_done = 1'b0;

  always #10 clk = ~clk;

  fft_butterfly #(.n(n), .d(d), .num_mults(num_mults)) u_fft_butterfly (
    .clk(clk),
    .reset(reset),
    .in_val(in_val),
    .in_rdy(in_rdy),
    .a_re(a_re),
    .a_im(a_im),
    .b_re(b_re),
    .b_im(b_im),
    .k(k),
    .out_val(out_val),
    .out_rdy(out_rdy),
    .x_re(x_re),
    .x_im(x_im),
    .y_re(y_re),
    .y_im(y_im)
  );

  // signed product, shifted right by d with rounding down, wrapped to n bits
  function automatic logic [n-1:0] trunc_mul(input logic [n-1:0] x, input logic [n-1:0] y);
    logic signed [2*n-1:0] xs;
    logic signed [2*n-1:0] ys;
    logic signed [2*n-1:0] full;
    xs = {{n{x[n-1]}}, x};
    ys = {{n{y[n-1]}}, y};
    full = xs * ys;
    return full[d +: n]; // bits d and up are the shifted value
  endfunction

  function automatic logic [4*n-1:0] add_sub(input logic [n-1:0] ar, input logic [n-1:0] ai,
                                             input logic [n-1:0] pr, input logic [n-1:0] pi);
    return {ar + pr, ai + pi, ar - pr, ai - pi};
  endfunction

  function automatic logic [4*n-1:0] butterfly_ref(
    input logic [n-1:0] ar, input logic [n-1:0] ai,
    input logic [n-1:0] br, input logic [n-1:0] bi, input logic [TW_ADDR_W-1:0] kk);
    logic [n-1:0] wr;
    logic [n-1:0] wi;
    logic [n-1:0] w_sum;
    logic [n-1:0] b_sum;
    logic [n-1:0] rr;
    logic [n-1:0] ii;
    logic [n-1:0] ss;
    wr = tw_mem[kk][2*n-1:n];
    wi = tw_mem[kk][n-1:0];
    w_sum = wr + wi;
    b_sum = br + bi;
    rr = trunc_mul(wr, br);
    ii = trunc_mul(wi, bi);
    ss = trunc_mul(w_sum, b_sum);
    return add_sub(ar, ai, rr - ii, ss - rr - ii);
  endfunction

  // called 1 ns after a rising edge, returns 1 ns after the edge that took the request
  task automatic send_req(input logic [n-1:0] ar, input logic [n-1:0] ai,
                          input logic [n-1:0] br, input logic [n-1:0] bi,
                          input logic [TW_ADDR_W-1:0] kk, input logic [4*n-1:0] expected);
    logic accepted;
    in_val = 1'b1;
    a_re = ar;
    a_im = ai;
    b_re = br;
    b_im = bi;
    k = kk;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_rdy;
      if (accepted) exp_q.push_back(expected);
      @(posedge clk);
      #1;
    end
  endtask

  // only for k = 0 or b = 0, where w*b is b itself or zero
  task automatic send_direct(input logic [n-1:0] ar, input logic [n-1:0] ai,
                             input logic [n-1:0] br, input logic [n-1:0] bi,
                             input logic [TW_ADDR_W-1:0] kk);
    send_req(ar, ai, br, bi, kk, add_sub(ar, ai, br, bi));
  endtask

  task automatic send_random();
    logic [n-1:0] ar;
    logic [n-1:0] ai;
    logic [n-1:0] br;
    logic [n-1:0] bi;
    logic [31:0] r;
    ar = $random(seed);
    ai = $random(seed);
    br = $random(seed);
    bi = $random(seed);
    r = $random(seed);
    send_req(ar, ai, br, bi, r[TW_ADDR_W-1:0], butterfly_ref(ar, ai, br, bi, r[TW_ADDR_W-1:0]));
  endtask

  initial begin : ready_pattern
    logic [31:0] r;
    logic next_rdy;
    out_rdy = 1'b1;
    forever begin
      @(negedge clk);
      if (rdy_mode != 2) stall_cycles = 0;
      else if (in_val && !in_rdy) stall_cycles++;
      else if (stall_cycles < stall_min) stall_cycles = 0; // a gap starts the count again
      case (rdy_mode)
        1: begin
          r = $random(rdy_seed);
          next_rdy = (r[1:0] != 2'b00); // low about a quarter of the time
        end
        2: next_rdy = (stall_cycles >= stall_min);
        default: next_rdy = 1'b1;
      endcase
      @(posedge clk);
      #1;
      out_rdy = next_rdy;
    end
  end

  always @(negedge clk) begin : compare_outputs
    logic [4*n-1:0] expected;
    logic [4*n-1:0] got;
    if (!reset && out_val && out_rdy) begin
      assert (exp_q.size() > 0) else begin
        cmp_done = 1'b1;
        $display("result at %0t ns arrived with no request pending", $time);
        $display("Errors found");
        $fatal(1, "extra result");
      end
      expected = exp_q.pop_front();
      got = {x_re, x_im, y_re, y_im};
      assert (got === expected) else begin
        cmp_done = 1'b1;
        $display("FAIL %0t ns: result %0d got %h expected %h", $time, n_out, got, expected);
        $display("Errors found");
        $fatal(1, "result mismatch");
      end
      n_out++;
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    assert (cycles < max_cycles) else begin
      tmo_done = 1'b1;
      $display("timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin : main_sequence
    logic [TW_ADDR_W-1:0] kk;
    logic [n-1:0] big_vals [4];
    $readmemh("twiddle.mem", tw_mem);
    reset = 1'b1;
    in_val = 1'b0;
    a_re = '0;
    a_im = '0;
    b_re = '0;
    b_im = '0;
    k = '0;
    big_vals[0] = {1'b0, {(n-1){1'b1}}}; // most positive
    big_vals[1] = {1'b1, {(n-1){1'b0}}}; // most negative
    big_vals[2] = '1;
    big_vals[3] = {2'b01, {(n-2){1'b0}}};
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // unit twiddle, zero b and real-only samples
    send_direct(32'h0003_0000, 32'hfffe_0000, 32'h0001_8000, 32'h0000_4000, 4'd0);
    send_direct(32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 4'd5);
    send_direct(32'h0001_2345, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 4'd9);
    send_direct(32'h0002_0000, 32'h0000_0000, 32'h0000_8000, 32'h0000_0000, 4'd0);
    send_direct(32'hffff_0000, 32'h0000_0000, 32'hfffc_0000, 32'h0000_0000, 4'd0);
    send_direct(32'd100, 32'd200, 32'hffff_fff9, 32'd9, 4'd0);

    repeat (200) send_random();

    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        kk = TW_ADDR_W'(i * 4 + j);
        send_req(big_vals[i], big_vals[j], big_vals[3-j], big_vals[i], kk,
                 butterfly_ref(big_vals[i], big_vals[j], big_vals[3-j], big_vals[i], kk));
      end
    end

    rdy_mode = 1;
    repeat (100) send_random();

    // the output stays blocked until in_rdy has been low for stall_min cycles in a row
    rdy_mode = 2;
    repeat (8) send_random();
    in_val = 1'b0;
    assert (stall_cycles >= stall_min) else begin
      main_done = 1'b1;
      $display("in_rdy did not stay low while out_rdy was held low");
      $display("Errors found");
      $fatal(1, "no stall");
    end
    rdy_mode = 0;

    while (exp_q.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk); // room for a stray extra result to show up
    main_done = 1'b1;
    $display("No errors");
    $finish;
  end

  // the bound checker can stop the run without passing through the processes above
  final begin
    if (!main_done && !cmp_done && !tmo_done) begin
      $display("Errors found");
    end
  end

endmodule

//--- twiddle.mem
// w(k) = exp(-j*2*pi*k/32) in Q16.16, one line per k from 0 to 15
// upper 8 hex digits are the real part, lower 8 hex digits the imaginary part
0001000000000000
0000FB15FFFFCE0F
0000EC83FFFF9E08
0000D4DBFFFF71C6
0000B505FFFF4AFB
00008E3AFFFF2B25
000061F8FFFF137D
000031F1FFFF04EB
00000000FFFF0000
FFFFCE0FFFFF04EB
FFFF9E08FFFF137D
FFFF71C6FFFF2B25
FFFF4AFBFFFF4AFB
FFFF2B25FFFF71C6
FFFF137DFFFF9E08
FFFF04EBFFFFCE0F

//--- vlog.f
common/fft_pkg.sv
common/cplx_if.sv
source/fp_mult.sv
cmult/cmult.sv
source/twiddle_rom.sv
source/bfly_issue.sv
source/bfly_combine.sv
source/fft_butterfly.sv
test/fft_butterfly_checker.sv
test/fft_butterfly_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the testbench once for each complex multiplier build
cd "$(dirname "$0")" || exit 1

result=0
for mults in 1 3; do
  obj_dir="obj_dir_m${mults}"
  log="sim_m${mults}.log"
  echo "building with num_mults=${mults}"
  verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fft_butterfly_tb -Gnum_mults=${mults} \
    --Mdir "${obj_dir}" -f vlog.f
  if [ $? -ne 0 ]; then
    echo "build failed for num_mults=${mults}"
    exit 1
  fi
  "./${obj_dir}/Vfft_butterfly_tb" > "${log}" 2>&1
  sim_status=$?
  cat "${log}"
  if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status} for num_mults=${mults}"
    result=1
  fi
  if grep -q "Errors found" "${log}"; then
    echo "num_mults=${mults}: FAILED"
    result=1
  else
    echo "num_mults=${mults}: passed"
  fi
done
exit ${result}
